// File: design/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int ADDR_W = 32;

	// one cache line is four words
	localparam int LINE_BEATS = 4;
	localparam logic [7:0] BURST_LEN = 8'(LINE_BEATS - 1);

	localparam logic [1:0] AXI_WRAP = 2'b10;
	localparam logic [2:0] AXI_SIZE_WORD = 3'b010; // 4 bytes per beat

	// defaults for the top level parameters
	localparam int PORT_NUM_DEF = 2;
	localparam int MEM_WORDS_DEF = 256;

	// byte address, or line / word / byte split
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic [ADDR_W-5:0] line;
			logic [1:0] word;
			logic [1:0] byte_off;
		} f;
	} mem_addr_u;

endpackage

`default_nettype wire

// File: design/axi_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_mem_if import cache_bus_pkg::*; (
	input wire clk
);

	logic [ADDR_W-1:0] awaddr;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic awvalid;
	logic awready;

	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;

	logic bvalid;
	logic bready;

	logic [ADDR_W-1:0] araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;

	logic [DATA_W-1:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;

	modport master (
		input clk,
		output awaddr, awlen, awsize, awburst, awvalid,
		input awready,
		output wdata, wstrb, wlast, wvalid,
		input wready,
		input bvalid,
		output bready,
		output araddr, arlen, arsize, arburst, arvalid,
		input arready,
		input rdata, rlast, rvalid,
		output rready
	);

	modport slave (
		input clk,
		input awaddr, awlen, awsize, awburst, awvalid,
		output awready,
		input wdata, wstrb, wlast, wvalid,
		output wready,
		output bvalid,
		input bready,
		input araddr, arlen, arsize, arburst, arvalid,
		output arready,
		output rdata, rlast, rvalid,
		input rready
	);

endinterface

`default_nettype wire

// File: design/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter import cache_bus_pkg::*; #(
	parameter int PORT_NUM = PORT_NUM_DEF
) (
	input wire clk,
	input wire rst_n,
	input wire [PORT_NUM-1:0] req_i,
	input wire take_i,
	output logic [PORT_NUM-1:0] grant_o
);

	localparam int PTR_W = (PORT_NUM > 1) ? $clog2(PORT_NUM) : 1;

	logic [PTR_W-1:0] ptr_r;
	logic [PTR_W-1:0] win_idx;
	logic found;

	// first requester at or after the pointer
	always_comb begin
		grant_o = '0;
		win_idx = ptr_r;
		found = 1'b0;
		for (int k = 0; k < PORT_NUM; k++) begin
			if (!found && req_i[(int'(ptr_r) + k) % PORT_NUM]) begin
				found = 1'b1;
				win_idx = PTR_W'((int'(ptr_r) + k) % PORT_NUM);
			end
		end
		if (found)
			grant_o[win_idx] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_r <= '0;
		end else if (take_i && found) begin
			// winner drops to lowest priority
			ptr_r <= (win_idx == PTR_W'(PORT_NUM - 1)) ? '0 : win_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/axi_converter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_converter import cache_bus_pkg::*; #(
	parameter int PORT_NUM = PORT_NUM_DEF
) (
	input wire clk,
	input wire rst_n,
	input wire [PORT_NUM-1:0] req_valid_i,
	input wire [PORT_NUM-1:0] req_write_i,
	input wire [PORT_NUM-1:0] req_burst_i,
	input wire [PORT_NUM-1:0][ADDR_W-1:0] req_addr_i,
	input wire [PORT_NUM-1:0] wr_data_ok_i,
	input wire [PORT_NUM-1:0] wr_last_i,
	input wire [PORT_NUM-1:0][STRB_W-1:0] wr_strb_i,
	input wire [PORT_NUM-1:0][DATA_W-1:0] wr_data_i,
	output logic [PORT_NUM-1:0] req_ready_o,
	output logic [PORT_NUM-1:0] data_ok_o,
	output logic [PORT_NUM-1:0] data_last_o,
	output logic [DATA_W-1:0] rd_data_o,
	axi_mem_if.master mem
);

	localparam logic [3:0] ST_IDLE = 4'b0001;
	localparam logic [3:0] ST_ADDR = 4'b0010;
	localparam logic [3:0] ST_DATA = 4'b0100;
	localparam logic [3:0] ST_RESP = 4'b1000;

	logic [3:0] state, state_nxt; // one hot
	logic [PORT_NUM-1:0] grant;
	logic [PORT_NUM-1:0] owner_r;
	logic take, accept;

	mem_addr_u grant_addr;
	logic grant_write, grant_burst;
	mem_addr_u addr_r;
	logic write_r, burst_r;

	logic sel_ok, sel_last;
	logic [STRB_W-1:0] sel_strb;
	logic [DATA_W-1:0] sel_data;

	logic w_open, w_hs, r_hs;
	logic last_taken; // cache already handed over its last word
	logic wr_valid_r, wr_last_r;
	logic [STRB_W-1:0] wr_strb_r;
	logic [DATA_W-1:0] wr_data_r;

	rr_arbiter #(.PORT_NUM(PORT_NUM)) rr_arbiter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_i(req_valid_i),
		.take_i(take),
		.grant_o(grant)
	);

	assign take = state[0];
	assign accept = take & (|grant);
	assign req_ready_o = grant & {PORT_NUM{take}};

	// request fields of the granted port, write fields of the owner
	always_comb begin
		grant_addr.raw = '0;
		grant_write = 1'b0;
		grant_burst = 1'b0;
		sel_ok = 1'b0;
		sel_last = 1'b0;
		sel_strb = '0;
		sel_data = '0;
		for (int i = 0; i < PORT_NUM; i++) begin
			if (grant[i]) begin
				grant_addr.raw = req_addr_i[i];
				grant_write = req_write_i[i];
				grant_burst = req_burst_i[i];
			end
			if (owner_r[i]) begin
				sel_ok = wr_data_ok_i[i];
				sel_last = wr_last_i[i];
				sel_strb = wr_strb_i[i];
				sel_data = wr_data_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_r <= grant_addr;
			write_r <= grant_write;
			burst_r <= grant_burst;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			owner_r <= '0;
		else if (accept)
			owner_r <= grant;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: if (accept) state_nxt = ST_ADDR;
			ST_ADDR: begin
				if (write_r ? (mem.awvalid & mem.awready) : (mem.arvalid & mem.arready))
					state_nxt = ST_DATA;
			end
			ST_DATA: begin
				if (!write_r && r_hs && mem.rlast)
					state_nxt = ST_IDLE;
				else if (write_r && w_hs && mem.wlast)
					state_nxt = ST_RESP;
			end
			ST_RESP: if (mem.bvalid && mem.bready) state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	assign w_hs = mem.wvalid & mem.wready;
	assign r_hs = mem.rvalid & mem.rready;

	// skid word may fill while AW is still in flight
	assign w_open = write_r & (state[1] | state[2]) & ~last_taken & (~wr_valid_r | w_hs);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_valid_r <= 1'b0;
			last_taken <= 1'b0;
		end else if (accept) begin
			last_taken <= 1'b0;
		end else if (w_open) begin
			wr_valid_r <= sel_ok;
			if (sel_ok && sel_last)
				last_taken <= 1'b1;
		end else if (w_hs) begin
			wr_valid_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (w_open) begin
			wr_data_r <= sel_data;
			wr_strb_r <= sel_strb;
			wr_last_r <= sel_last;
		end
	end

	assign data_ok_o = owner_r & {PORT_NUM{w_open | r_hs}};
	assign data_last_o = owner_r & {PORT_NUM{r_hs & mem.rlast}};
	assign rd_data_o = mem.rdata;

	always_comb begin
		mem.awaddr = addr_r.raw;
		mem.awlen = burst_r ? BURST_LEN : 8'd0;
		mem.awsize = AXI_SIZE_WORD;
		mem.awburst = AXI_WRAP;
		mem.awvalid = state[1] & write_r;

		mem.wdata = wr_data_r;
		mem.wstrb = wr_strb_r;
		mem.wlast = wr_last_r; // cache marks its own last beat
		mem.wvalid = wr_valid_r & state[2];
		mem.bready = state[3];

		mem.araddr = addr_r.raw;
		mem.arlen = burst_r ? BURST_LEN : 8'd0;
		mem.arsize = AXI_SIZE_WORD;
		mem.arburst = AXI_WRAP;
		mem.arvalid = state[1] & ~write_r;

		mem.rready = state[2] & ~write_r; // cache never stalls reads
	end

endmodule

`default_nettype wire

// File: design/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave import cache_bus_pkg::*; #(
	parameter int MEM_WORDS = MEM_WORDS_DEF
) (
	input wire clk,
	input wire rst_n,
	axi_mem_if.slave bus
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_WR = 3'd1;
	localparam logic [2:0] S_RESP = 3'd2;
	localparam logic [2:0] S_AR = 3'd3;
	localparam logic [2:0] S_RD = 3'd4;

	logic [2:0] state;
	logic [DATA_W-1:0] mem [MEM_WORDS];

	mem_addr_u addr_r, addr_step;
	logic [7:0] len_r, cnt_r;
	logic [IDX_W-1:0] idx, idx_step;
	logic [DATA_W-1:0] rdata_r;
	logic w_hs, r_hs;

	always_comb begin
		addr_step = addr_r;
		addr_step.f.word = addr_r.f.word + 2'd1; // wraps inside the line
	end

	// word index, aliased modulo the depth
	assign idx = IDX_W'({addr_r.f.line, addr_r.f.word} % MEM_WORDS);
	assign idx_step = IDX_W'({addr_step.f.line, addr_step.f.word} % MEM_WORDS);

	assign w_hs = bus.wvalid & bus.wready;
	assign r_hs = bus.rvalid & bus.rready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (bus.awvalid)
						state <= S_WR;
					else if (bus.arvalid)
						state <= S_AR;
				end
				S_WR: if (w_hs && bus.wlast) state <= S_RESP;
				S_RESP: if (bus.bready) state <= S_IDLE;
				S_AR: state <= S_RD; // arvalid is held until arready
				S_RD: if (r_hs && bus.rlast) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				cnt_r <= '0;
				if (bus.awvalid) begin
					addr_r.raw <= bus.awaddr;
				end else if (bus.arvalid) begin
					addr_r.raw <= bus.araddr;
					len_r <= bus.arlen;
				end
			end
			S_WR: if (w_hs) addr_r <= addr_step;
			S_AR: rdata_r <= mem[idx]; // critical word
			S_RD: begin
				if (r_hs && !bus.rlast) begin
					addr_r <= addr_step;
					cnt_r <= cnt_r + 8'd1;
					rdata_r <= mem[idx_step];
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == S_WR && w_hs) begin
			for (int b = 0; b < STRB_W; b++)
				if (bus.wstrb[b])
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
		end
	end

	assign bus.awready = (state == S_WR);
	assign bus.wready = (state == S_WR);
	assign bus.bvalid = (state == S_RESP);
	assign bus.arready = (state == S_AR);
	assign bus.rvalid = (state == S_RD);
	assign bus.rdata = rdata_r;
	assign bus.rlast = (state == S_RD) && (cnt_r == len_r);

endmodule

`default_nettype wire

// File: design/cache_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mem_subsys import cache_bus_pkg::*; #(
	parameter int PORT_NUM = PORT_NUM_DEF,
	parameter int MEM_WORDS = MEM_WORDS_DEF
) (
	input wire clk,
	input wire rst_n,
	input wire [PORT_NUM-1:0] req_valid_i,
	input wire [PORT_NUM-1:0] req_write_i,
	input wire [PORT_NUM-1:0] req_burst_i,
	input wire [PORT_NUM-1:0][ADDR_W-1:0] req_addr_i,
	input wire [PORT_NUM-1:0] wr_data_ok_i,
	input wire [PORT_NUM-1:0] wr_last_i,
	input wire [PORT_NUM-1:0][STRB_W-1:0] wr_strb_i,
	input wire [PORT_NUM-1:0][DATA_W-1:0] wr_data_i,
	output logic [PORT_NUM-1:0] req_ready_o,
	output logic [PORT_NUM-1:0] data_ok_o,
	output logic [PORT_NUM-1:0] data_last_o,
	output logic [DATA_W-1:0] rd_data_o
);

	axi_mem_if mem_bus (
		.clk(clk)
	);

	// cache ports in, single AXI4 master out
	axi_converter #(
		.PORT_NUM(PORT_NUM)
	) axi_converter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid_i(req_valid_i),
		.req_write_i(req_write_i),
		.req_burst_i(req_burst_i),
		.req_addr_i(req_addr_i),
		.wr_data_ok_i(wr_data_ok_i),
		.wr_last_i(wr_last_i),
		.wr_strb_i(wr_strb_i),
		.wr_data_i(wr_data_i),
		.req_ready_o(req_ready_o),
		.data_ok_o(data_ok_o),
		.data_last_o(data_last_o),
		.rd_data_o(rd_data_o),
		.mem(mem_bus.master)
	);

	axi_sram_slave #(
		.MEM_WORDS(MEM_WORDS)
	) axi_sram_slave_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bus(mem_bus.slave)
	);

endmodule

`default_nettype wire

// File: tests/cache_mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mem_subsys_tb import cache_bus_pkg::*; ();

	localparam int PORT_NUM = 2;
	localparam int MEM_WORDS = 256;
	localparam logic [ADDR_W-1:0] PORT_STRIDE = 32'h100; // port p works p regions higher
	localparam int NUM_ROWS = 11;
	localparam int CYCLE_LIMIT = NUM_ROWS * 40;

	typedef struct packed {
		logic [PORT_NUM-1:0] mask;
		logic write;
		logic burst;
		logic [ADDR_W-1:0] addr;
		logic [STRB_W-1:0] strb;
		logic seeded; // data from the lfsr
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{2'b11, 1'b1, 1'b0, 32'h0000_0040, 4'hf, 1'b1}, // both ports right after reset
		'{2'b01, 1'b1, 1'b0, 32'h0000_0010, 4'hf, 1'b0},
		'{2'b01, 1'b0, 1'b0, 32'h0000_0010, 4'hf, 1'b0},
		'{2'b01, 1'b1, 1'b1, 32'h0000_0088, 4'hf, 1'b1}, // line 0x80 from word 2
		'{2'b01, 1'b0, 1'b1, 32'h0000_0084, 4'hf, 1'b0}, // beats 1 2 3 0
		'{2'b01, 1'b1, 1'b0, 32'h0000_0020, 4'hf, 1'b1},
		'{2'b01, 1'b1, 1'b0, 32'h0000_0020, 4'b0110, 1'b1}, // middle bytes only
		'{2'b01, 1'b0, 1'b0, 32'h0000_0020, 4'hf, 1'b0},
		'{2'b11, 1'b0, 1'b0, 32'h0000_0040, 4'hf, 1'b0}, // port 1 ahead this time
		'{2'b10, 1'b1, 1'b0, 32'h0000_0c30, 4'hf, 1'b1}, // 0xd30 aliases 0x130
		'{2'b01, 1'b0, 1'b0, 32'h0000_0130, 4'hf, 1'b0}
	};

	logic clk;
	logic rst_n;
	logic [PORT_NUM-1:0] req_valid;
	logic [PORT_NUM-1:0] req_write;
	logic [PORT_NUM-1:0] req_burst;
	logic [PORT_NUM-1:0][ADDR_W-1:0] req_addr;
	logic [PORT_NUM-1:0] wr_data_ok;
	logic [PORT_NUM-1:0] wr_last;
	logic [PORT_NUM-1:0][STRB_W-1:0] wr_strb;
	logic [PORT_NUM-1:0][DATA_W-1:0] wr_data;
	logic [PORT_NUM-1:0] req_ready;
	logic [PORT_NUM-1:0] data_ok;
	logic [PORT_NUM-1:0] data_last;
	logic [DATA_W-1:0] rd_data;

	logic [DATA_W-1:0] shadow [MEM_WORDS];
	logic [31:0] lfsr_q;
	int rr_ptr; // expected arbiter pointer
	int checks;
	int errors;
	int cycles;

	cache_mem_subsys #(
		.PORT_NUM(PORT_NUM),
		.MEM_WORDS(MEM_WORDS)
	) cache_mem_subsys_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid_i(req_valid),
		.req_write_i(req_write),
		.req_burst_i(req_burst),
		.req_addr_i(req_addr),
		.wr_data_ok_i(wr_data_ok),
		.wr_last_i(wr_last),
		.wr_strb_i(wr_strb),
		.wr_data_i(wr_data),
		.req_ready_o(req_ready),
		.data_ok_o(data_ok),
		.data_last_o(data_last),
		.rd_data_o(rd_data)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_val(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_rand_word(output logic [DATA_W-1:0] w);
		w = '0;
		for (int i = 0; i < DATA_W; i++) begin
			w = {w[DATA_W-2:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
		end
	endtask

	task automatic make_word(input row_t r, input int p, input logic [ADDR_W-1:0] a,
			input int beat, output logic [DATA_W-1:0] w);
		if (r.seeded)
			take_rand_word(w);
		else
			w = {8'hc0, 8'(p), a[15:2], 2'(beat)};
	endtask

	function automatic logic [ADDR_W-1:0] port_addr(input logic [ADDR_W-1:0] a, input int p);
		return a + PORT_STRIDE * ADDR_W'(p);
	endfunction

	// word of a beat, wrapping inside the line, then modulo the depth
	function automatic int beat_index(input logic [ADDR_W-1:0] a, input int beat);
		longint line;
		longint off;
		line = longint'(a[ADDR_W-1:4]);
		off = (longint'(a[3:2]) + beat) % LINE_BEATS;
		return int'((line * LINE_BEATS + off) % MEM_WORDS);
	endfunction

	function automatic int expected_winner(input logic [PORT_NUM-1:0] pending, input int ptr);
		int idx;
		for (int k = 0; k < PORT_NUM; k++) begin
			idx = (ptr + k) % PORT_NUM;
			if (pending[idx])
				return idx;
		end
		return -1;
	endfunction

	task automatic wait_grant(output int g);
		logic [PORT_NUM-1:0] seen;
		seen = '0;
		g = -1;
		while (seen == '0) begin
			@(negedge clk);
			check_val(DATA_W'(req_ready & ~req_valid), '0, "req_ready_o at a port with no request");
			check_val(DATA_W'(data_ok), '0, "data_ok_o while no transfer is open");
			seen = req_ready;
			@(posedge clk);
			#1;
		end
		check_val(DATA_W'($countones(seen)), 32'd1, "req_ready_o is not one-hot");
		for (int k = PORT_NUM - 1; k >= 0; k--)
			if (seen[k])
				g = k;
	endtask

	task automatic write_phase(input row_t r, input int p, input logic [ADDR_W-1:0] a);
		int nbeats;
		int beat;
		int idx;
		logic moved;
		logic [PORT_NUM-1:0] own;
		logic [DATA_W-1:0] word;
		own = '0;
		own[p] = 1'b1;
		nbeats = r.burst ? LINE_BEATS : 1;
		beat = 0;
		make_word(r, p, a, beat, word);
		wr_data[p] = word;
		wr_strb[p] = r.strb;
		wr_last[p] = (nbeats == 1);
		wr_data_ok[p] = 1'b1;
		while (beat < nbeats) begin
			@(negedge clk);
			check_val(DATA_W'(data_ok & ~own), '0, "data_ok_o at a port that does not own the write");
			check_val(DATA_W'(data_last), '0, "data_last_o during a write");
			moved = data_ok[p];
			@(posedge clk);
			#1;
			if (moved) begin
				idx = beat_index(a, beat);
				for (int b = 0; b < STRB_W; b++)
					if (r.strb[b])
						shadow[idx][8*b +: 8] = word[8*b +: 8];
				beat++;
				if (beat < nbeats) begin
					make_word(r, p, a, beat, word);
					wr_data[p] = word;
					wr_last[p] = (beat == nbeats - 1);
				end else begin
					wr_data_ok[p] = 1'b0;
					wr_last[p] = 1'b0;
				end
			end
		end
	endtask

	task automatic read_phase(input row_t r, input int p, input logic [ADDR_W-1:0] a);
		int nbeats;
		int beat;
		logic [PORT_NUM-1:0] own;
		own = '0;
		own[p] = 1'b1;
		nbeats = r.burst ? LINE_BEATS : 1;
		beat = 0;
		while (beat < nbeats) begin
			@(negedge clk);
			check_val(DATA_W'(data_ok & ~own), '0, "data_ok_o at a port that does not own the read");
			check_val(DATA_W'(data_last & ~own), '0, "data_last_o at a port that does not own the read");
			if (data_ok[p]) begin
				check_val(rd_data, shadow[beat_index(a, beat)],
					$sformatf("port %0d read beat %0d at %h", p, beat, a));
				check_val(DATA_W'(data_last[p]), DATA_W'(beat == nbeats - 1),
					$sformatf("data_last_o on beat %0d", beat));
				beat++;
			end else begin
				check_val(DATA_W'(data_last[p]), '0, "data_last_o without data_ok_o");
			end
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_row(input int n);
		row_t r;
		logic [PORT_NUM-1:0] pending;
		int g;
		int exp_g;
		r = ROWS[n];
		pending = r.mask;
		for (int p = 0; p < PORT_NUM; p++) begin
			if (pending[p]) begin
				req_valid[p] = 1'b1;
				req_write[p] = r.write;
				req_burst[p] = r.burst;
				req_addr[p] = port_addr(r.addr, p);
			end
		end
		while (pending != '0) begin
			exp_g = expected_winner(pending, rr_ptr);
			wait_grant(g);
			check_val(DATA_W'(g), DATA_W'(exp_g), $sformatf("grant order in row %0d", n));
			rr_ptr = (exp_g + 1) % PORT_NUM;
			req_valid[g] = 1'b0;
			pending[g] = 1'b0;
			if (r.write)
				write_phase(r, g, port_addr(r.addr, g));
			else
				read_phase(r, g, port_addr(r.addr, g));
		end
	endtask

	initial begin
		checks = 0;
		errors = 0;
		rr_ptr = 0;
		lfsr_q = 32'd40;
		rst_n = 1'b0;
		req_valid = '0;
		req_write = '0;
		req_burst = '0;
		req_addr = '0;
		wr_data_ok = '0;
		wr_last = '0;
		wr_strb = '0;
		wr_data = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// quiet bus until someone asks
		repeat (2) begin
			@(negedge clk);
			check_val(DATA_W'(req_ready), '0, "req_ready_o after reset");
			check_val(DATA_W'(data_ok), '0, "data_ok_o after reset");
			check_val(DATA_W'(data_last), '0, "data_last_o after reset");
		end
		@(posedge clk);
		#1;

		for (int n = 0; n < NUM_ROWS; n++)
			run_row(n);
		repeat (2) @(posedge clk);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: cache_mem_subsys.f
design/cache_bus_pkg.sv
design/axi_mem_if.sv
design/rr_arbiter.sv
design/axi_converter.sv
design/axi_sram_slave.sv
design/cache_mem_subsys.sv
tests/cache_mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module cache_mem_subsys_tb \
	-f cache_mem_subsys.f \
	--Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
